/* design/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

  localparam int INST_WIDTH     = 16;
  localparam int DATA_WIDTH     = 16;
  localparam int REG_ADDR_WIDTH = 4;  // 16 registers

  // Instruction bits 15:12
  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_OR   = 4'h4,
    OP_XOR  = 4'h5,
    OP_ADDI = 4'h6,  // rd = rs + sext(imm4)
    OP_LUI  = 4'h7,  // rd = {imm8, 8'h00}
    OP_HALT = 4'hf
  } opcode_t;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RUN   = 2'd1,
    ST_DRAIN = 2'd2,
    ST_DONE  = 2'd3
  } core_state_t;

endpackage

`default_nettype wire

/* design/pipe_stage_reg.sv */
`timescale 1ns/10ps
`default_nettype none

// Zero is a bubble in every stage, so flush and reset both clear

module pipe_stage_reg #(
  parameter int WIDTH = 16
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  input  logic             flush,
  input  logic [WIDTH-1:0] d,
  output logic [WIDTH-1:0] q
);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

/* design/pc_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_counter #(
  parameter int IMEM_ADDR_WIDTH = 5
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start_pulse,
  input  logic                       stall,
  input  logic                       run,
  output logic [IMEM_ADDR_WIDTH-1:0] pc
);

  always_ff @(posedge clk) begin
    if (reset || start_pulse) begin
      pc <= '0;
    end else if (run && !stall) begin
      pc <= pc + 1'b1;  // Wraps at memory depth
    end
  end

endmodule

`default_nettype wire

/* design/hazard_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_ctrl (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                start_pulse,
  input  logic                                halt_in_decode,
  input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0] rs_addr,
  input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0] rt_addr,
  input  logic                                rs_used,
  input  logic                                rt_used,
  input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0] id_ex_rd,
  input  logic                                id_ex_we,
  input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0] ex_wb_rd,
  input  logic                                ex_wb_we,
  output logic                                run,
  output logic                                fetch_stall,
  output logic                                if_id_stall,
  output logic                                if_id_flush,
  output logic                                id_ex_flush,
  output logic                                ex_wb_flush,
  output logic                                busy,
  output logic                                done
);
  import pipe_pkg::*;

  localparam int DRAIN_CYCLES = 2;

  core_state_t state;
  logic [1:0]  drain_cnt;
  logic        raw_hazard;
  logic        halt_seen;

  // Source still waiting on a write from execute or writeback
  function automatic logic pending_write(input logic [REG_ADDR_WIDTH-1:0] addr);
    pending_write = (addr != '0) &&
                    ((id_ex_we && id_ex_rd == addr) || (ex_wb_we && ex_wb_rd == addr));
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      drain_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE, ST_DONE: begin
          if (start_pulse) state <= ST_RUN;
        end
        ST_RUN: begin
          if (halt_in_decode) begin
            state     <= ST_DRAIN;
            drain_cnt <= '0;
          end
        end
        ST_DRAIN: begin
          drain_cnt <= drain_cnt + 2'd1;
          if (drain_cnt == 2'(DRAIN_CYCLES - 1)) state <= ST_DONE;  // Last writeback done
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign run  = (state == ST_RUN);
  assign busy = (state == ST_RUN) || (state == ST_DRAIN);
  assign done = (state == ST_DONE);

  assign raw_hazard = (rs_used && pending_write(rs_addr)) ||
                      (rt_used && pending_write(rt_addr));
  assign halt_seen  = run && halt_in_decode;

  assign fetch_stall = raw_hazard || halt_seen;
  assign if_id_stall = raw_hazard;
  assign if_id_flush = start_pulse || halt_seen || !run;  // Nothing fetched outside run
  assign id_ex_flush = start_pulse || raw_hazard;         // Bubble behind a stalled decode
  assign ex_wb_flush = start_pulse;

endmodule

`default_nettype wire

/* design/decode_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_regfile (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                start_pulse,
  input  logic [pipe_pkg::INST_WIDTH-1:0]     inst,
  input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0] wb_rd,
  input  logic [pipe_pkg::DATA_WIDTH-1:0]     wb_data,
  input  logic                                wb_we,
  input  logic [pipe_pkg::REG_ADDR_WIDTH-1:0] host_reg_addr,
  output pipe_pkg::opcode_t                   opcode,
  output logic [pipe_pkg::REG_ADDR_WIDTH-1:0] rd_addr,
  output logic [pipe_pkg::REG_ADDR_WIDTH-1:0] rs_addr,
  output logic [pipe_pkg::REG_ADDR_WIDTH-1:0] rt_addr,
  output logic                                rs_used,
  output logic                                rt_used,
  output logic [pipe_pkg::DATA_WIDTH-1:0]     rs_data,
  output logic [pipe_pkg::DATA_WIDTH-1:0]     rt_data,
  output logic [pipe_pkg::DATA_WIDTH-1:0]     imm_data,
  output logic                                write_en,
  output logic                                halt_in_decode,
  output logic [pipe_pkg::DATA_WIDTH-1:0]     host_reg_data,
  output logic [pipe_pkg::DATA_WIDTH-1:0]     retire_count
);
  import pipe_pkg::*;

  localparam int NUM_REGS = 1 << REG_ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] regs [NUM_REGS];

  // Register 0 reads zero; a same-cycle writeback is passed straight through
  function automatic logic [DATA_WIDTH-1:0] read_reg(input logic [REG_ADDR_WIDTH-1:0] addr);
    if (addr == '0) read_reg = '0;
    else if (wb_we && wb_rd == addr) read_reg = wb_data;
    else read_reg = regs[addr];
  endfunction

  always_comb begin
    case (inst[INST_WIDTH-1 -: 4])
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
      OP_ADDI, OP_LUI, OP_HALT: opcode = opcode_t'(inst[INST_WIDTH-1 -: 4]);
      default:                  opcode = OP_NOP;  // Unused codes
    endcase
  end

  assign rd_addr = inst[11:8];
  assign rs_addr = inst[7:4];
  assign rt_addr = inst[3:0];

  always_comb begin
    rs_used  = 1'b0;
    rt_used  = 1'b0;
    write_en = 1'b0;
    imm_data = '0;
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
        rs_used  = 1'b1;
        rt_used  = 1'b1;
        write_en = 1'b1;
      end
      OP_ADDI: begin
        rs_used  = 1'b1;
        write_en = 1'b1;
        imm_data = {{(DATA_WIDTH-4){inst[3]}}, inst[3:0]};
      end
      OP_LUI: begin
        write_en = 1'b1;
        imm_data = {inst[7:0], 8'h00};
      end
      default: ;
    endcase
  end

  assign halt_in_decode = (opcode == OP_HALT);

  assign rs_data       = read_reg(rs_addr);
  assign rt_data       = read_reg(rt_addr);
  assign host_reg_data = (host_reg_addr == '0) ? '0 : regs[host_reg_addr];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
    end else if (wb_we && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Every write-enabled result counts, register 0 included
  always_ff @(posedge clk) begin
    if (reset || start_pulse) begin
      retire_count <= '0;
    end else if (wb_we) begin
      retire_count <= retire_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/alu_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_exec (
  input  pipe_pkg::opcode_t               opcode,
  input  logic [pipe_pkg::DATA_WIDTH-1:0] rs_data,
  input  logic [pipe_pkg::DATA_WIDTH-1:0] rt_data,
  input  logic [pipe_pkg::DATA_WIDTH-1:0] imm_data,
  output logic [pipe_pkg::DATA_WIDTH-1:0] result
);
  import pipe_pkg::*;

  logic                  use_imm;
  logic [DATA_WIDTH-1:0] operand_b;

  assign use_imm   = (opcode == OP_ADDI) || (opcode == OP_LUI);
  assign operand_b = use_imm ? imm_data : rt_data;

  always_comb begin
    case (opcode)
      OP_ADD,
      OP_ADDI: result = rs_data + operand_b;  // Wraps at 16 bits
      OP_SUB:  result = rs_data - operand_b;
      OP_AND:  result = rs_data & operand_b;
      OP_OR:   result = rs_data | operand_b;
      OP_XOR:  result = rs_data ^ operand_b;
      OP_LUI:  result = operand_b;            // Upper byte already placed
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/imem_host.sv */
`timescale 1ns/10ps
`default_nettype none

module imem_host #(
  parameter int IMEM_ADDR_WIDTH = 5
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                cyc,
  input  logic                                stb,
  input  logic                                we,
  input  logic [7:0]                          adr,
  input  logic [pipe_pkg::DATA_WIDTH-1:0]     dat_w,
  input  logic [IMEM_ADDR_WIDTH-1:0]          pc,
  input  logic                                busy,
  input  logic                                done,
  input  logic [pipe_pkg::DATA_WIDTH-1:0]     host_reg_data,
  input  logic [pipe_pkg::DATA_WIDTH-1:0]     retire_count,
  output logic [pipe_pkg::DATA_WIDTH-1:0]     dat_r,
  output logic                                ack,
  output logic                                start_pulse,
  output logic [pipe_pkg::INST_WIDTH-1:0]     fetch_inst,
  output logic [pipe_pkg::REG_ADDR_WIDTH-1:0] host_reg_addr
);
  import pipe_pkg::*;

  logic [INST_WIDTH-1:0] imem [1 << IMEM_ADDR_WIDTH];
  logic                  req;
  logic [1:0]            sel;
  logic [DATA_WIDTH-1:0] read_mux;

  assign req = cyc && stb && !ack;  // New request, not the one just acked
  assign sel = adr[7:6];

  assign host_reg_addr = adr[REG_ADDR_WIDTH-1:0];
  assign fetch_inst    = imem[pc];

  always_comb begin
    case (sel)
      2'd1:    read_mux = host_reg_data;
      2'd2:    read_mux = {{(DATA_WIDTH-2){1'b0}}, done, busy};
      2'd3:    read_mux = retire_count;
      default: read_mux = '0;  // Instruction memory is write only
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ack         <= 1'b0;
      start_pulse <= 1'b0;
    end else begin
      ack         <= req;
      start_pulse <= req && we && sel == 2'd2 && dat_w[0] && !busy;
    end
  end

  always_ff @(posedge clk) begin
    if (req && we && sel == 2'd0 && !busy) begin
      imem[adr[IMEM_ADDR_WIDTH-1:0]] <= dat_w;
    end
    if (req && !we) begin
      dat_r <= read_mux;
    end
  end

endmodule

`default_nettype wire

/* design/mini_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mini_core_top #(
  parameter int IMEM_ADDR_WIDTH = 5
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            cyc,
  input  logic                            stb,
  input  logic                            we,
  input  logic [7:0]                      adr,
  input  logic [pipe_pkg::DATA_WIDTH-1:0] dat_w,
  output logic [pipe_pkg::DATA_WIDTH-1:0] dat_r,
  output logic                            ack
);
  import pipe_pkg::*;

  localparam int OP_BITS     = $bits(opcode_t);
  localparam int ID_EX_WIDTH = OP_BITS + REG_ADDR_WIDTH + 3 * DATA_WIDTH + 1;
  localparam int EX_WB_WIDTH = REG_ADDR_WIDTH + DATA_WIDTH + 1;

  logic                       start_pulse;
  logic                       busy;
  logic                       done;
  logic                       run;
  logic                       fetch_stall;
  logic                       if_id_stall;
  logic                       if_id_flush;
  logic                       id_ex_flush;
  logic                       ex_wb_flush;
  logic [IMEM_ADDR_WIDTH-1:0] pc;
  logic [INST_WIDTH-1:0]      fetch_inst;
  logic [INST_WIDTH-1:0]      id_inst;
  logic [REG_ADDR_WIDTH-1:0]  host_reg_addr;
  logic [DATA_WIDTH-1:0]      host_reg_data;
  logic [DATA_WIDTH-1:0]      retire_count;

  // Decode stage
  opcode_t                   dec_opcode;
  logic [REG_ADDR_WIDTH-1:0] dec_rd;
  logic [REG_ADDR_WIDTH-1:0] dec_rs;
  logic [REG_ADDR_WIDTH-1:0] dec_rt;
  logic                      rs_used;
  logic                      rt_used;
  logic [DATA_WIDTH-1:0]     dec_rs_data;
  logic [DATA_WIDTH-1:0]     dec_rt_data;
  logic [DATA_WIDTH-1:0]     dec_imm;
  logic                      dec_we;
  logic                      halt_in_decode;

  // Execute and writeback stages
  logic [ID_EX_WIDTH-1:0]    id_ex_q;
  logic [OP_BITS-1:0]        ex_op_bits;
  logic [REG_ADDR_WIDTH-1:0] ex_rd;
  logic [DATA_WIDTH-1:0]     ex_rs_data;
  logic [DATA_WIDTH-1:0]     ex_rt_data;
  logic [DATA_WIDTH-1:0]     ex_imm;
  logic                      ex_we;
  logic [DATA_WIDTH-1:0]     ex_result;
  logic [EX_WB_WIDTH-1:0]    ex_wb_q;
  logic [REG_ADDR_WIDTH-1:0] wb_rd;
  logic [DATA_WIDTH-1:0]     wb_data;
  logic                      wb_we;

  imem_host #(.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)) u_imem_host (
    .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
    .pc(pc), .busy(busy), .done(done), .host_reg_data(host_reg_data),
    .retire_count(retire_count), .dat_r(dat_r), .ack(ack), .start_pulse(start_pulse),
    .fetch_inst(fetch_inst), .host_reg_addr(host_reg_addr)
  );

  hazard_ctrl u_hazard_ctrl (
    .clk(clk), .reset(reset), .start_pulse(start_pulse), .halt_in_decode(halt_in_decode),
    .rs_addr(dec_rs), .rt_addr(dec_rt), .rs_used(rs_used), .rt_used(rt_used),
    .id_ex_rd(ex_rd), .id_ex_we(ex_we), .ex_wb_rd(wb_rd), .ex_wb_we(wb_we),
    .run(run), .fetch_stall(fetch_stall), .if_id_stall(if_id_stall),
    .if_id_flush(if_id_flush), .id_ex_flush(id_ex_flush), .ex_wb_flush(ex_wb_flush),
    .busy(busy), .done(done)
  );

  pc_counter #(.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)) u_pc_counter (
    .clk(clk), .reset(reset), .start_pulse(start_pulse), .stall(fetch_stall),
    .run(run), .pc(pc)
  );

  pipe_stage_reg #(.WIDTH(INST_WIDTH)) u_if_id (
    .clk(clk), .reset(reset), .stall(if_id_stall), .flush(if_id_flush),
    .d(fetch_inst), .q(id_inst)
  );

  decode_regfile u_decode_regfile (
    .clk(clk), .reset(reset), .start_pulse(start_pulse), .inst(id_inst),
    .wb_rd(wb_rd), .wb_data(wb_data), .wb_we(wb_we), .host_reg_addr(host_reg_addr),
    .opcode(dec_opcode), .rd_addr(dec_rd), .rs_addr(dec_rs), .rt_addr(dec_rt),
    .rs_used(rs_used), .rt_used(rt_used), .rs_data(dec_rs_data), .rt_data(dec_rt_data),
    .imm_data(dec_imm), .write_en(dec_we), .halt_in_decode(halt_in_decode),
    .host_reg_data(host_reg_data), .retire_count(retire_count)
  );

  // Write enable sits at bit 0 of both later stages
  pipe_stage_reg #(.WIDTH(ID_EX_WIDTH)) u_id_ex (
    .clk(clk), .reset(reset), .stall(1'b0), .flush(id_ex_flush),
    .d({dec_opcode, dec_rd, dec_rs_data, dec_rt_data, dec_imm, dec_we}), .q(id_ex_q)
  );

  assign {ex_op_bits, ex_rd, ex_rs_data, ex_rt_data, ex_imm, ex_we} = id_ex_q;

  alu_exec u_alu_exec (
    .opcode(opcode_t'(ex_op_bits)), .rs_data(ex_rs_data), .rt_data(ex_rt_data),
    .imm_data(ex_imm), .result(ex_result)
  );

  pipe_stage_reg #(.WIDTH(EX_WB_WIDTH)) u_ex_wb (
    .clk(clk), .reset(reset), .stall(1'b0), .flush(ex_wb_flush),
    .d({ex_rd, ex_result, ex_we}), .q(ex_wb_q)
  );

  assign {wb_rd, wb_data, wb_we} = ex_wb_q;

endmodule

`default_nettype wire

/* dv/mini_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mini_core_tb;
  import pipe_pkg::*;

  localparam int IMEM_ADDR_WIDTH = 5;
  localparam int IMEM_DEPTH      = 1 << IMEM_ADDR_WIDTH;
  localparam int NUM_TESTS       = 6;
  localparam int CLK_PERIOD      = 4;
  localparam int ACK_LIMIT       = 8;
  localparam int POLL_LIMIT      = IMEM_DEPTH * 20;
  localparam logic [7:0] STATUS_ADR = 8'h80;
  localparam logic [7:0] COUNT_ADR  = 8'hc0;

  logic                  clk;
  logic                  reset;
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [7:0]            adr;
  logic [DATA_WIDTH-1:0] dat_w;
  logic [DATA_WIDTH-1:0] dat_r;
  logic                  ack;

  logic [31:0]           lfsr_state;
  logic [INST_WIDTH-1:0] prog [$];
  logic [DATA_WIDTH-1:0] model_regs [16];
  logic [DATA_WIDTH-1:0] model_count;

  mini_core_top #(.IMEM_ADDR_WIDTH(IMEM_ADDR_WIDTH)) u_mini_core_top (
    .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_TESTS * IMEM_DEPTH * 20 * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    abort_run();
  end

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
    rand_bits = v;
  endfunction

  function automatic logic [15:0] encode_reg_op(input opcode_t op, input logic [3:0] rd,
                                                input logic [3:0] rs, input logic [3:0] rt);
    encode_reg_op = {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] encode_lui(input logic [3:0] rd, input logic [7:0] imm);
    encode_lui = {OP_LUI, rd, imm};
  endfunction

  task automatic wait_ack();
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!ack && waited < ACK_LIMIT);
    if (!ack) begin
      $display("No ack from the DUT within %0d cycles", ACK_LIMIT);
      abort_run();
    end
    check_value("ack latency", 16'(waited), 16'd1);
  endtask

  task automatic wb_write(input logic [7:0] addr, input logic [15:0] data);
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = addr;
    dat_w = data;
    wait_ack();
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wb_read(input logic [7:0] addr, output logic [15:0] data);
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = addr;
    wait_ack();
    data = dat_r;  // Registered with the ack
    cyc  = 1'b0;
    stb  = 1'b0;
  endtask

  // Executes prog in order and keeps registers across programs
  task automatic run_model();
    logic [15:0] inst;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic        wr;
    int          i;
    model_count = '0;
    for (i = 0; i < prog.size(); i++) begin
      inst = prog[i];
      if (inst[15:12] == OP_HALT) break;
      a  = model_regs[inst[7:4]];
      b  = model_regs[inst[3:0]];
      wr = 1'b1;
      res = '0;
      case (inst[15:12])
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_OR:   res = a | b;
        OP_XOR:  res = a ^ b;
        OP_ADDI: res = a + {{12{inst[3]}}, inst[3:0]};
        OP_LUI:  res = {inst[7:0], 8'h00};
        default: wr = 1'b0;
      endcase
      if (wr) begin
        model_count++;
        if (inst[11:8] != 4'd0) model_regs[inst[11:8]] = res;
      end
    end
  endtask

  task automatic load_program();
    int i;
    for (i = 0; i < prog.size(); i++) begin
      wb_write({3'b000, 5'(i)}, prog[i]);
    end
    run_model();
  endtask

  task automatic wait_done();
    logic [15:0] status;
    int          polls;
    polls  = 0;
    status = '0;
    while (!status[1] && polls < POLL_LIMIT) begin
      wb_read(STATUS_ADR, status);
      polls++;
    end
    if (!status[1]) begin
      $display("Core did not report done after %0d status reads", POLL_LIMIT);
      abort_run();
    end
    check_value("busy at done", {15'd0, status[0]}, 16'd0);
  endtask

  task automatic check_results();
    logic [15:0] data;
    int          r;
    for (r = 0; r < 16; r++) begin
      wb_read({4'b0100, 4'(r)}, data);
      check_value($sformatf("register r%0d", r), data, model_regs[r]);
    end
    wb_read(COUNT_ADR, data);
    check_value("retire count", data, model_count);
  endtask

  task automatic push_chain();
    prog.push_back(encode_lui(4'd1, 8'(rand_bits(8))));
    prog.push_back(encode_reg_op(OP_ADDI, 4'd1, 4'd1, 4'(rand_bits(4))));  // Distance 1
    prog.push_back(encode_reg_op(OP_ADDI, 4'd2, 4'd1, 4'(rand_bits(4))));
    prog.push_back(encode_reg_op(OP_ADD, 4'd3, 4'd2, 4'd1));               // Distances 1 and 2
    prog.push_back(encode_reg_op(OP_SUB, 4'd4, 4'd3, 4'd2));
    prog.push_back(encode_reg_op(OP_XOR, 4'd5, 4'd4, 4'd3));
    prog.push_back(encode_reg_op(OP_AND, 4'd6, 4'd5, 4'd3));
    prog.push_back(encode_reg_op(OP_OR, 4'd7, 4'd6, 4'd4));
    prog.push_back(encode_reg_op(OP_ADDI, 4'd7, 4'd7, 4'(rand_bits(4))));
    prog.push_back(encode_reg_op(OP_SUB, 4'd8, 4'd7, 4'd1));
    prog.push_back(encode_reg_op(OP_ADD, 4'd8, 4'd8, 4'd8));
    prog.push_back({OP_HALT, 12'h000});
  endtask

  task automatic run_and_check();
    load_program();
    wb_write(STATUS_ADR, 16'h0001);
    wait_done();
    check_results();
  endtask

  task automatic test_reset_state();
    logic [15:0] data;
    wb_read(STATUS_ADR, data);
    check_value("status after reset", data, 16'h0000);
    wb_read(COUNT_ADR, data);
    check_value("retire count after reset", data, 16'h0000);
  endtask

  task automatic test_independent();
    int r;
    prog.delete();
    for (r = 1; r <= 4; r++) prog.push_back(encode_lui(4'(r), 8'(rand_bits(8))));
    prog.push_back(encode_reg_op(OP_ADDI, 4'd5, 4'd0, 4'(rand_bits(4))));
    prog.push_back(encode_reg_op(OP_ADDI, 4'd6, 4'd0, 4'(rand_bits(4))));
    prog.push_back(encode_reg_op(OP_ADD, 4'd7, 4'd1, 4'd2));
    prog.push_back(encode_reg_op(OP_SUB, 4'd8, 4'd3, 4'd4));
    prog.push_back(encode_reg_op(OP_AND, 4'd9, 4'd1, 4'd3));
    prog.push_back(encode_reg_op(OP_OR, 4'd10, 4'd2, 4'd4));
    prog.push_back(encode_reg_op(OP_XOR, 4'd11, 4'd5, 4'd6));
    prog.push_back({OP_HALT, 12'h000});
    run_and_check();
  endtask

  task automatic test_dependent_chain();
    prog.delete();
    push_chain();
    run_and_check();
  endtask

  task automatic test_zero_writes();
    prog.delete();
    prog.push_back(encode_reg_op(OP_ADDI, 4'd0, 4'd0, 4'(rand_bits(4))));
    prog.push_back(encode_lui(4'd0, 8'(rand_bits(8))));
    prog.push_back(encode_reg_op(OP_ADD, 4'd0, 4'd1, 4'd2));
    prog.push_back(encode_reg_op(OP_ADD, 4'd3, 4'd0, 4'd1));  // r0 read right after a write
    prog.push_back({OP_HALT, 12'h000});
    run_and_check();
  endtask

  task automatic test_busy_ignored();
    logic [15:0] status;
    prog.delete();
    prog.push_back(encode_reg_op(OP_ADDI, 4'd15, 4'd15, 4'd3));  // Applied twice on a restart
    push_chain();
    load_program();
    wb_write(STATUS_ADR, 16'h0001);
    wb_read(STATUS_ADR, status);
    check_value("status while running", status, 16'h0001);
    // Would replace a word not yet fetched
    wb_write(8'(prog.size() - 2), encode_lui(4'd9, 8'ha5));
    wb_write(STATUS_ADR, 16'h0001);
    wb_read(STATUS_ADR, status);
    check_value("status after ignored writes", status, 16'h0001);
    wait_done();
    check_results();

    prog.delete();
    prog.push_back(encode_lui(4'd12, 8'(rand_bits(8))));
    prog.push_back(encode_reg_op(OP_ADDI, 4'd13, 4'd0, 4'(rand_bits(4))));
    prog.push_back(encode_reg_op(OP_XOR, 4'd14, 4'd12, 4'd13));
    prog.push_back({OP_HALT, 12'h000});
    run_and_check();
  endtask

  task automatic test_halt_only();
    prog.delete();
    prog.push_back({OP_HALT, 12'h000});
    run_and_check();
  endtask

  initial begin
    int i;
    lfsr_state = 32'h5475;
    reset = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    for (i = 0; i < 16; i++) model_regs[i] = '0;
    model_count = '0;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    test_reset_state();
    test_independent();
    test_dependent_chain();
    test_zero_writes();
    test_busy_ignored();
    test_halt_only();

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
design/pipe_pkg.sv
design/pipe_stage_reg.sv
design/pc_counter.sv
design/hazard_ctrl.sv
design/decode_regfile.sv
design/alu_exec.sv
design/imem_host.sv
design/mini_core_top.sv
dv/mini_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module mini_core_tb -o sim

# The simulator exit status is not used, the log decides
./obj_dir/sim | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi
echo "Simulation finished without errors"
